//--- Bender.yml
package:
  name: sram_subsystem

sources:
  - include_dirs:
      - .
    files:
      - sram_pkg.sv
      - bank_select.sv
      - sram_half_ctrl.sv
      - response_merge.sv
      - sram_subsystem.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_sram_chip.sv
      - tb_checker.sv
      - tb_sram_subsystem.sv

//--- bank_select.sv
`timescale 1ns/1ps
`include "sram_cfg.svh"

module bank_select (
  input  logic                                 clock,
  input  logic                                 reset,
  input  sram_pkg::mem_req_t                   req,
  input  logic                                 rsp_ready,
  output sram_pkg::mem_req_t [`SRAM_BANKS-1:0] bank_req,
  output logic [`SRAM_BANK_W-1:0]              sel_bank
);

  logic [`SRAM_BANK_W-1:0] req_bank;
  logic                    busy;

  assign req_bank = req.addr[`SRAM_BANK_LSB +: `SRAM_BANK_W];

  always_comb begin
    for (int i = 0; i < `SRAM_BANKS; i++) begin
      bank_req[i] = req; // address and data go to every bank.
      bank_req[i].valid = req.valid && (req_bank == i);
    end
  end

  // the pending bank stays selected until the merged response has gone out.
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
      sel_bank <= '0;
    end else if (req.valid && !busy) begin
      busy <= 1'b1;
      sel_bank <= req_bank;
    end else if (rsp_ready) begin
      busy <= 1'b0;
    end
  end

  // A new request must wait for the cycle after the host has seen ready.
  a_no_valid_while_busy : assert property (
    @(posedge clock) disable iff (reset)
    req.valid |-> !busy
  ) else $error("request issued while bank %0d is still busy", sel_bank);

  // ready reaches the host only for an access this block has accepted.
  a_ready_only_when_busy : assert property (
    @(posedge clock) disable iff (reset)
    rsp_ready |-> busy
  ) else $error("response ready without an outstanding request");

endmodule

//--- response_merge.sv
`timescale 1ns/1ps
`include "sram_cfg.svh"

module response_merge (
  input  logic                                 clock,
  input  logic                                 reset,
  input  sram_pkg::mem_rsp_t [`SRAM_BANKS-1:0] bank_rsp,
  input  logic [`SRAM_BANK_W-1:0]              sel_bank,
  output sram_pkg::mem_rsp_t                   rsp
);

  sram_pkg::mem_rsp_t sel_rsp;

  assign sel_rsp = bank_rsp[sel_bank];

  always_ff @(posedge clock) begin
    if (reset) begin
      rsp.ready <= 1'b0;
    end else begin
      rsp.ready <= sel_rsp.ready;
    end
  end

  // read data only moves when the selected bank finishes.
  always_ff @(posedge clock) begin
    if (sel_rsp.ready) begin
      rsp.rdata <= sel_rsp.rdata;
    end
  end

  for (genvar i = 0; i < `SRAM_BANKS; i++) begin : g_bank_chk
    a_only_selected_ready : assert property (
      @(posedge clock) disable iff (reset)
      bank_rsp[i].ready |-> (sel_bank == i)
    ) else $error("bank %0d ready while bank %0d is selected", i, sel_bank);
  end

endmodule

//--- sram_cfg.svh
`ifndef SRAM_CFG_SVH
`define SRAM_CFG_SVH

`define SRAM_BANKS 2
`define SRAM_BANK_W $clog2(`SRAM_BANKS)

`define SRAM_HALF_AW 18
`define SRAM_DW 16
`define SRAM_BANK_LSB 19

`endif

//--- sram_half_ctrl.sv
`timescale 1ns/1ps
`include "sram_cfg.svh"

module sram_half_ctrl (
  input  logic                 clock,
  input  logic                 reset,
  input  sram_pkg::mem_req_t   req,
  output sram_pkg::mem_rsp_t   rsp,
  output sram_pkg::sram_pins_t pins,
  inout  logic [`SRAM_DW-1:0]  sram_d
);

  sram_pkg::access_kind_e   kind;
  sram_pkg::half_phase_e    phase;
  logic                     is_read;
  logic                     two_cycle;
  logic                     upper;
  logic [`SRAM_HALF_AW-1:0] half_addr;
  logic [`SRAM_HALF_AW-1:0] next_addr;
  logic [`SRAM_DW-1:0]      wdata_hi;
  logic [`SRAM_DW-1:0]      dout;
  logic [31:0]              rdata;
  logic                     ready;

  always_comb begin
    case (req.wstrb)
      4'b0000:        kind = sram_pkg::acc_read;
      4'b1111:        kind = sram_pkg::acc_word;
      4'b0011,
      4'b1100:        kind = sram_pkg::acc_half;
      default:        kind = sram_pkg::acc_byte;
    endcase
  end

  assign two_cycle = (kind == sram_pkg::acc_read) || (kind == sram_pkg::acc_word);
  assign upper = (req.wstrb[1:0] == 2'b00); // lanes 2 and 3 live in the next halfword.
  assign half_addr = req.addr[`SRAM_HALF_AW:1];

  // The first half is driven straight from the request, the second from registers.
  always_comb begin
    pins = '{a: '0, lb_n: 1'b1, ub_n: 1'b1, ce_n: 1'b1, oe_n: 1'b1, we_n: 1'b1};
    dout = '0;
    if (phase == sram_pkg::phase_high) begin
      pins.a = next_addr;
      pins.lb_n = 1'b0;
      pins.ub_n = 1'b0;
      pins.ce_n = 1'b0;
      pins.oe_n = !is_read;
      pins.we_n = is_read;
      dout = wdata_hi;
    end else if (req.valid) begin
      pins.ce_n = 1'b0;
      case (kind)
        sram_pkg::acc_read: begin
          pins.a = half_addr;
          pins.lb_n = 1'b0;
          pins.ub_n = 1'b0;
          pins.oe_n = 1'b0;
        end
        sram_pkg::acc_word: begin
          pins.a = half_addr;
          pins.lb_n = 1'b0;
          pins.ub_n = 1'b0;
          pins.we_n = 1'b0;
          dout = req.wdata[15:0];
        end
        default: begin
          pins.a = half_addr + `SRAM_HALF_AW'(upper);
          pins.lb_n = !(upper ? req.wstrb[2] : req.wstrb[0]);
          pins.ub_n = !(upper ? req.wstrb[3] : req.wstrb[1]);
          pins.we_n = 1'b0;
          dout = upper ? req.wdata[31:16] : req.wdata[15:0]; // bytes already sit in lane.
        end
      endcase
    end
  end

  assign sram_d = pins.we_n ? 'z : dout;

  always_ff @(posedge clock) begin
    if (reset) begin
      phase <= sram_pkg::phase_low;
      is_read <= 1'b0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (phase == sram_pkg::phase_high) begin
        phase <= sram_pkg::phase_low;
        ready <= 1'b1;
      end else if (req.valid) begin
        is_read <= (kind == sram_pkg::acc_read);
        if (two_cycle) begin
          phase <= sram_pkg::phase_high;
        end else begin
          ready <= 1'b1; // sub-word writes finish in one cycle.
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (phase == sram_pkg::phase_low && req.valid) begin
      next_addr <= half_addr + `SRAM_HALF_AW'(1);
      wdata_hi <= req.wdata[31:16];
      if (kind == sram_pkg::acc_read) begin
        rdata[15:0] <= sram_d;
      end
    end else if (phase == sram_pkg::phase_high && is_read) begin
      rdata[31:16] <= sram_d;
    end
  end

  assign rsp.ready = ready;
  assign rsp.rdata = rdata;

  a_no_bus_fight : assert property (
    @(posedge clock) disable iff (reset)
    !(!pins.oe_n && !pins.we_n)
  ) else $error("output and write enable low together");

  a_ce_with_access : assert property (
    @(posedge clock) disable iff (reset)
    (!pins.oe_n || !pins.we_n) |-> !pins.ce_n
  ) else $error("sram access without chip enable");

  a_ready_pulse : assert property (
    @(posedge clock) disable iff (reset)
    rsp.ready |=> !rsp.ready
  ) else $error("bank ready held for more than one cycle");

endmodule

//--- sram_patterns.txt
# columns: op addr wdata wstrb expected_rdata, all hex
# op 0 reads and compares with expected_rdata, op 1 writes (expected_rdata unused)
1 00000100 11223344 f 00000000
0 00000100 00000000 0 11223344
1 00080100 a5a5c3c3 f 00000000
0 00000100 00000000 0 11223344
0 00080100 00000000 0 a5a5c3c3
1 00000100 000000ee 1 00000000
1 00000100 99000000 8 00000000
0 00000100 00000000 0 992233ee
1 00000100 beef0000 c 00000000
0 00000100 00000000 0 beef33ee
1 00080100 00001234 3 00000000
1 00080100 00770000 4 00000000
1 00080100 00005600 2 00000000
0 00080100 00000000 0 a5775634
1 0007fffc cafef00d f 00000000
0 0007fffc 00000000 0 cafef00d
1 000ffffc 0badc0de f 00000000
0 000ffffc 00000000 0 0badc0de
1 00000104 55667788 f 00000000
0 00000100 00000000 0 beef33ee
0 00000104 00000000 0 55667788
0 00080100 00000000 0 a5775634

//--- sram_pkg.sv
`include "sram_cfg.svh"

package sram_pkg;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb; // all zero means a read.
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic [`SRAM_HALF_AW-1:0] a;
    logic                     lb_n;
    logic                     ub_n;
    logic                     ce_n;
    logic                     oe_n;
    logic                     we_n;
  } sram_pins_t;

  typedef enum logic {
    phase_low,
    phase_high
  } half_phase_e;

  typedef enum logic [1:0] {
    acc_read,
    acc_word,
    acc_half,
    acc_byte
  } access_kind_e;

endpackage

//--- sram_subsystem.sv
`timescale 1ns/1ps
`include "sram_cfg.svh"

module sram_subsystem (
  input  logic                                   clock,
  input  logic                                   reset,
  input  sram_pkg::mem_req_t                     req,
  output sram_pkg::mem_rsp_t                     rsp,
  output sram_pkg::sram_pins_t [`SRAM_BANKS-1:0] pins,
  inout  logic [`SRAM_BANKS-1:0][`SRAM_DW-1:0]   sram_d
);

  sram_pkg::mem_req_t [`SRAM_BANKS-1:0] bank_req;
  sram_pkg::mem_rsp_t [`SRAM_BANKS-1:0] bank_rsp;
  logic [`SRAM_BANK_W-1:0]              sel_bank;

  bank_select u_bank_select (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .rsp_ready (rsp.ready),
    .bank_req  (bank_req),
    .sel_bank  (sel_bank)
  );

  for (genvar i = 0; i < `SRAM_BANKS; i++) begin : g_bank
    sram_half_ctrl u_ctrl (
      .clock  (clock),
      .reset  (reset),
      .req    (bank_req[i]),
      .rsp    (bank_rsp[i]),
      .pins   (pins[i]),
      .sram_d (sram_d[i])
    );
  end

  response_merge u_response_merge (
    .clock    (clock),
    .reset    (reset),
    .bank_rsp (bank_rsp),
    .sel_bank (sel_bank),
    .rsp      (rsp)
  );

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps
`include "sram_cfg.svh"

module tb_checker (
  input  logic                                   clock,
  input  logic                                   reset,
  input  sram_pkg::mem_req_t                     req,
  input  sram_pkg::mem_rsp_t                     rsp,
  input  sram_pkg::sram_pins_t [`SRAM_BANKS-1:0] pins,
  input  logic [31:0]                            exp_rdata,
  input  logic                                   check_rdata,
  output int                                     errors
);

  logic                    reset_q;
  logic                    ready_q;
  logic                    pending;
  int                      cycles;
  sram_pkg::access_kind_e  pend_kind;
  logic [`SRAM_BANK_W-1:0] pend_bank;
  logic [31:0]             pend_exp;
  logic                    pend_check;

  initial begin
    errors = 0;
    reset_q = 1'b0;
    ready_q = 1'b0;
    pending = 1'b0;
    cycles = 0;
    pend_bank = '0;
  end

  function automatic sram_pkg::access_kind_e kind_of(input logic [3:0] strb);
    int ones;
    ones = strb[0] + strb[1] + strb[2] + strb[3];
    case (ones)
      0:       return sram_pkg::acc_read;
      4:       return sram_pkg::acc_word;
      2:       return sram_pkg::acc_half;
      default: return sram_pkg::acc_byte;
    endcase
  endfunction

  function automatic logic [`SRAM_BANK_W-1:0] bank_of(input logic [31:0] addr);
    return addr[`SRAM_BANK_LSB +: `SRAM_BANK_W];
  endfunction

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic check_idle_pins(input string when);
    for (int i = 0; i < `SRAM_BANKS; i++) begin
      if ({pins[i].ce_n, pins[i].oe_n, pins[i].we_n, pins[i].lb_n, pins[i].ub_n} !== 5'b11111)
        report_error($sformatf("bank %0d control pins not all high %s", i, when));
    end
    if (rsp.ready !== 1'b0) report_error($sformatf("rsp.ready not low %s", when));
  endtask

  task automatic check_request_pins(input sram_pkg::access_kind_e kind,
                                    input logic [`SRAM_BANK_W-1:0] bank);
    sram_pkg::sram_pins_t     p;
    logic [`SRAM_HALF_AW-1:0] ha;
    logic                     up;
    logic                     exp_lb_n;
    logic                     exp_ub_n;
    p = pins[bank];
    ha = req.addr[`SRAM_HALF_AW:1];
    up = 1'b0;
    exp_lb_n = 1'b0;
    exp_ub_n = 1'b0;
    if (kind == sram_pkg::acc_half || kind == sram_pkg::acc_byte) begin
      up = req.wstrb[2] | req.wstrb[3]; // lanes 2 and 3 sit in the next halfword.
      exp_lb_n = !(req.wstrb[0] | req.wstrb[2]); // even lanes are the low byte.
      exp_ub_n = !(req.wstrb[1] | req.wstrb[3]);
    end
    if (p.ce_n !== 1'b0)
      report_error($sformatf("%s on bank %0d left ce_n high", kind.name(), bank));
    if (p.a !== ha + up)
      report_error($sformatf("%s on bank %0d drove address %h, expected %h",
                             kind.name(), bank, p.a, ha + up));
    if (p.lb_n !== exp_lb_n || p.ub_n !== exp_ub_n)
      report_error($sformatf("%s lanes lb_n=%b ub_n=%b, expected %b %b",
                             kind.name(), p.lb_n, p.ub_n, exp_lb_n, exp_ub_n));
    if (kind == sram_pkg::acc_byte && (p.lb_n ^ p.ub_n) !== 1'b1)
      report_error("byte write does not enable exactly one lane");
    if (kind == sram_pkg::acc_read ? (p.oe_n !== 1'b0 || p.we_n !== 1'b1)
                                   : (p.we_n !== 1'b0 || p.oe_n !== 1'b1))
      report_error($sformatf("%s with oe_n=%b we_n=%b", kind.name(), p.oe_n, p.we_n));
  endtask

  // inputs and registered outputs are read here with their values from before the edge.
  always @(posedge clock) begin
    sram_pkg::access_kind_e  kind;
    logic [`SRAM_BANK_W-1:0] bank;
    int                      exp_lat;
    if (reset) begin
      if (reset_q) check_idle_pins("during reset");
      pending = 1'b0;
      ready_q = 1'b0;
    end else begin
      bank = (req.valid === 1'b1) ? bank_of(req.addr) : pend_bank;
      for (int i = 0; i < `SRAM_BANKS; i++) begin
        if (pins[i].oe_n === 1'b0 && pins[i].we_n === 1'b0)
          report_error($sformatf("bank %0d has oe_n and we_n low together", i));
        if (pins[i].ce_n === 1'b0 && !((req.valid === 1'b1 || pending) && bank == i))
          report_error($sformatf("bank %0d ce_n low while bank %0d is selected", i, bank));
      end
      if (pending) cycles++;
      if (!pending && req.valid !== 1'b1) check_idle_pins("while idle");
      if (rsp.ready === 1'b1) begin
        if (ready_q) begin
          report_error("rsp.ready high for two cycles");
        end else if (!pending) begin
          report_error("rsp.ready without a request");
        end else begin
          exp_lat = (pend_kind == sram_pkg::acc_read || pend_kind == sram_pkg::acc_word) ? 3 : 2;
          if (cycles != exp_lat)
            report_error($sformatf("%s ready after %0d cycles, expected %0d",
                                   pend_kind.name(), cycles, exp_lat));
          if (pend_check && rsp.rdata !== pend_exp)
            report_error($sformatf("read from bank %0d returned %h, expected %h",
                                   pend_bank, rsp.rdata, pend_exp));
        end
        pending = 1'b0;
      end
      if (req.valid === 1'b1) begin
        kind = kind_of(req.wstrb);
        check_request_pins(kind, bank);
        pending = 1'b1;
        cycles = 0;
        pend_kind = kind;
        pend_bank = bank;
        pend_exp = exp_rdata;
        pend_check = check_rdata;
      end
      ready_q = (rsp.ready === 1'b1);
    end
    reset_q = reset;
  end

endmodule

//--- tb_sram_chip.sv
`timescale 1ns/1ps
`include "sram_cfg.svh"

module tb_sram_chip (
  input  sram_pkg::sram_pins_t pins,
  inout  wire [`SRAM_DW-1:0]   d
);

  logic [`SRAM_DW-1:0] mem [0:(1 << `SRAM_HALF_AW)-1];
  logic [`SRAM_DW-1:0] rd_word;
  logic                reading;

  assign reading = !pins.ce_n && !pins.oe_n && pins.we_n;
  assign rd_word = mem[pins.a];

  // each byte lane drives the bus on its own.
  assign d[7:0]  = (reading && !pins.lb_n) ? rd_word[7:0] : 8'hzz;
  assign d[15:8] = (reading && !pins.ub_n) ? rd_word[15:8] : 8'hzz;

  // A write lands 1 ns after the pins and data stop moving, like a short write cycle.
  always begin
    @(pins or d);
    #1;
    if (!pins.ce_n && !pins.we_n) begin
      if (!pins.lb_n) begin
        mem[pins.a][7:0] = d[7:0];
      end
      if (!pins.ub_n) begin
        mem[pins.a][15:8] = d[15:8];
      end
    end
  end

endmodule

//--- tb_sram_subsystem.sv
`timescale 1ns/1ps
`include "sram_cfg.svh"

module tb_sram_subsystem;

  logic                                   clock;
  logic                                   reset;
  sram_pkg::mem_req_t                     req;
  sram_pkg::mem_rsp_t                     rsp;
  sram_pkg::sram_pins_t [`SRAM_BANKS-1:0] pins;
  wire  [`SRAM_BANKS-1:0][`SRAM_DW-1:0]   sram_d;
  logic [31:0]                            exp_rdata;
  logic                                   check_rdata;
  int                                     check_errors;
  int                                     timeouts;
  int                                     setup_errors;

  int             fd;
  int             got;
  int             count;
  logic           timed_out;
  logic [8*160:1] line;
  logic [31:0]    op;
  logic [31:0]    addr;
  logic [31:0]    wdata;
  logic [3:0]     strb;
  logic [31:0]    expd;

  sram_subsystem dut (
    .clock  (clock),
    .reset  (reset),
    .req    (req),
    .rsp    (rsp),
    .pins   (pins),
    .sram_d (sram_d)
  );

  for (genvar i = 0; i < `SRAM_BANKS; i++) begin : g_chip
    tb_sram_chip u_chip (
      .pins (pins[i]),
      .d    (sram_d[i])
    );
  end

  tb_checker u_checker (
    .clock       (clock),
    .reset       (reset),
    .req         (req),
    .rsp         (rsp),
    .pins        (pins),
    .exp_rdata   (exp_rdata),
    .check_rdata (check_rdata),
    .errors      (check_errors)
  );

  always #50 clock = ~clock;

  // one request per call, then wait for the merged ready.
  task automatic run_request(input logic [31:0] a, input logic [31:0] wd, input logic [3:0] st,
                             input logic [31:0] ed, input logic chk, output logic late);
    int waited;
    @(negedge clock);
    req.valid = 1'b1;
    req.addr = a;
    req.wdata = wd;
    req.wstrb = st;
    exp_rdata = ed;
    check_rdata = chk;
    @(negedge clock);
    req.valid = 1'b0;
    waited = 0;
    while (rsp.ready !== 1'b1 && waited < 20) begin
      @(negedge clock);
      waited++;
    end
    late = (rsp.ready !== 1'b1);
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    req = '0;
    exp_rdata = '0;
    check_rdata = 1'b0;
    timeouts = 0;
    setup_errors = 0;
    count = 0;
    timed_out = 1'b0;
    void'($urandom(32'h82206a5f));
    fd = $fopen("sram_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file sram_patterns.txt");
      setup_errors++;
    end
    repeat (5) @(negedge clock);
    reset = 1'b0;
    repeat (2) @(negedge clock);
    while (fd != 0 && !timed_out && !$feof(fd)) begin
      line = '0;
      got = $fgets(line, fd);
      if (got != 0 && $sscanf(line, "%h %h %h %h %h", op, addr, wdata, strb, expd) == 5) begin
        repeat ($urandom % 4) @(negedge clock);
        run_request(addr, wdata, strb, expd, op == 0, timed_out);
        if (timed_out) begin
          $display("request %0d at address %h got no ready within 20 cycles", count, addr);
          timeouts++;
        end
        count++;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
      if (count == 0) begin
        $display("the pattern file holds no requests");
        setup_errors++;
      end
    end
    repeat (3) @(negedge clock);
    $display("%0d requests, %0d checker errors, %0d timeouts, %0d setup errors",
             count, check_errors, timeouts, setup_errors);
    if (check_errors == 0 && timeouts == 0 && setup_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
sram_pkg.sv
bank_select.sv
sram_half_ctrl.sv
response_merge.sv
sram_subsystem.sv
tb_sram_chip.sv
tb_checker.sv
tb_sram_subsystem.sv
